//--- design/ras_pkg.sv
// Return address prediction package
// Default sizes, RISC-V jump opcodes, link registers and the stack action code

`default_nettype none

package ras_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////////////////////

  // Address width of one return entry
  localparam int XLEN_DEF   = 32;
  // Entries per hart stack
  localparam int DEPTH_DEF  = 4;
  // Number of harts sharing the fetch unit
  localparam int NHARTS_DEF = 4;

  ////////////////////////////////////////////////////////////////////////////
  // RISC-V encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes of the two unconditional jumps
  localparam logic [6:0] OPC_JAL  = 7'b110_1111;
  localparam logic [6:0] OPC_JALR = 7'b110_0111;

  // Link registers named by the calling convention
  // x1 is ra, x5 is the alternate link t0
  localparam logic [4:0] REG_RA = 5'd1;
  localparam logic [4:0] REG_T0 = 5'd5;

  ////////////////////////////////////////////////////////////////////////////
  // Stack action
  ////////////////////////////////////////////////////////////////////////////

  // What a jump does to its hart's return stack
  // Pop then push replaces the top entry in place
  typedef enum logic [1:0] {
    RAS_NONE     = 2'b00,
    RAS_PUSH     = 2'b01,
    RAS_POP      = 2'b10,
    RAS_POP_PUSH = 2'b11
  } ras_action_e;

endpackage

`default_nettype wire

//--- design/ras_stack_if.sv
// Return stack port bundle for one hart
// Decoder drives push side, stack drives top value and empty flag

`default_nettype none

interface ras_stack_if #(
  parameter int XLEN = 32
);

  // Update strobes, one cycle each
  logic            push;
  logic            pop;
  // Return address to push
  logic [XLEN-1:0] d;
  // Current top of stack, or last pushed value when empty
  logic [XLEN-1:0] q;
  // Stack holds no entries
  logic            empty;

  // Hint decoder side
  modport producer (
    output push,
    output pop,
    output d
  );

  // The stack itself
  modport stack (
    input  push,
    input  pop,
    input  d,
    output q,
    output empty
  );

  // Prediction selector side
  modport consumer (
    input  q,
    input  empty
  );

endinterface

`default_nettype wire

//--- design/ras_hint_decoder.sv
// Jump hint decoder
// Classifies one decoded jump by the link register rules and routes
// push/pop strobes plus the return address to the addressed hart

`default_nettype none

module ras_hint_decoder #(
  parameter int XLEN   = 32,
  parameter int NHARTS = 4,
  localparam int HART_W = (NHARTS > 1) ? $clog2(NHARTS) : 1
) (
  input  wire logic              instr_valid_i,
  input  wire logic              stall_i,
  input  wire logic [6:0]        opcode_i,
  input  wire logic [4:0]        rd_i,
  input  wire logic [4:0]        rs1_i,
  input  wire logic [XLEN-1:0]   pc_i,
  input  wire logic              rvc_i,
  input  wire logic [HART_W-1:0] hart_i,

  ras_stack_if.producer          stk_o [NHARTS]
);

  // Instruction size steps for the link address
  localparam logic [XLEN-1:0] RVC_STEP = XLEN'(2);
  localparam logic [XLEN-1:0] RVI_STEP = XLEN'(4);

  ////////////////////////////////////////////////////////////////////////////
  // Hint classification
  ////////////////////////////////////////////////////////////////////////////

  logic                  rd_link;
  logic                  rs1_link;
  ras_pkg::ras_action_e  action;
  logic                  do_push;
  logic                  do_pop;
  logic [XLEN-1:0]       ret_addr;
  logic [NHARTS-1:0]     hart_hit;

  // Either x1 or x5 counts as a link register
  assign rd_link  = (rd_i  == ras_pkg::REG_RA) || (rd_i  == ras_pkg::REG_T0);
  assign rs1_link = (rs1_i == ras_pkg::REG_RA) || (rs1_i == ras_pkg::REG_T0);

  // Nothing happens for an invalid slot or while fetch is stalled
  always_comb begin
    action = ras_pkg::RAS_NONE;
    if (instr_valid_i && !stall_i) begin
      if (opcode_i == ras_pkg::OPC_JAL) begin
        // Direct call only when it links
        if (rd_link) begin
          action = ras_pkg::RAS_PUSH;
        end
      end else if (opcode_i == ras_pkg::OPC_JALR) begin
        unique case ({rd_link, rs1_link})
          // Plain indirect jump
          2'b00: action = ras_pkg::RAS_NONE;
          // Function return
          2'b01: action = ras_pkg::RAS_POP;
          // Indirect call
          2'b10: action = ras_pkg::RAS_PUSH;
          // Coroutine swap when registers differ, else a call
          2'b11: action = (rd_i == rs1_i) ? ras_pkg::RAS_PUSH : ras_pkg::RAS_POP_PUSH;
          default: action = ras_pkg::RAS_NONE;
        endcase
      end
    end
  end

  // Pop then push drives both strobes together
  assign do_push = (action == ras_pkg::RAS_PUSH) || (action == ras_pkg::RAS_POP_PUSH);
  assign do_pop  = (action == ras_pkg::RAS_POP)  || (action == ras_pkg::RAS_POP_PUSH);

  // Address of the instruction after the jump
  assign ret_addr = pc_i + (rvc_i ? RVC_STEP : RVI_STEP);

  ////////////////////////////////////////////////////////////////////////////
  // Per hart routing
  ////////////////////////////////////////////////////////////////////////////

  // Only the addressed hart sees any activity
  for (genvar h = 0; h < NHARTS; h++) begin : g_hart
    assign hart_hit[h]   = (hart_i == HART_W'(h));
    assign stk_o[h].push = hart_hit[h] & do_push;
    assign stk_o[h].pop  = hart_hit[h] & do_pop;
    assign stk_o[h].d    = hart_hit[h] ? ret_addr : '0;
  end

endmodule

`default_nettype wire

//--- design/ras_stack.sv
// Per hart return stack
// Shift register stack with saturating depth count; while empty the
// top value falls back to the most recently pushed address

`default_nettype none

module ras_stack #(
  parameter int XLEN  = 32,
  parameter int DEPTH = 4
) (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,

  ras_stack_if.stack stk
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Entry 0 is the top of stack
  logic [XLEN-1:0]  entry [DEPTH];
  logic [XLEN-1:0]  last_pushed;
  logic [CNT_W-1:0] cnt;
  logic             empty_q;

  // Keep the newest push for prediction on an empty stack
  always_ff @(posedge clk_i) begin
    if (stk.push) begin
      last_pushed <= stk.d;
    end
  end

  // Shift down on push, up on pop, overwrite top on both
  always_ff @(posedge clk_i) begin
    unique case ({stk.push, stk.pop})
      2'b10: begin
        // Oldest entry falls off the bottom
        entry[0] <= stk.d;
        for (int n = 1; n < DEPTH; n++) begin
          entry[n] <= entry[n-1];
        end
      end
      2'b01: begin
        for (int n = 0; n < DEPTH - 1; n++) begin
          entry[n] <= entry[n+1];
        end
      end
      2'b11: entry[0] <= stk.d;
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////////////////////////////////////////

  // Count saturates at both ends
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt <= '0;
    end else begin
      unique case ({stk.push, stk.pop})
        2'b10:   if (cnt != CNT_W'(DEPTH)) cnt <= cnt + 1'b1;
        2'b01:   if (cnt != '0) cnt <= cnt - 1'b1;
        default: ;
      endcase
    end
  end

  // Registered empty flag tracks the count
  // A pop with zero or one entry leaves the stack empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      empty_q <= 1'b1;
    end else begin
      unique case ({stk.push, stk.pop})
        2'b10:   empty_q <= 1'b0;
        2'b01:   empty_q <= (cnt <= CNT_W'(1));
        default: ;
      endcase
    end
  end

  // Top of stack or fallback value
  assign stk.q     = empty_q ? last_pushed : entry[0];
  assign stk.empty = empty_q;

endmodule

`default_nettype wire

//--- design/ras_pred_select.sv
// Return address prediction selector
// Captures the top address and empty flag of the hart named by a lookup

`default_nettype none

module ras_pred_select #(
  parameter int XLEN   = 32,
  parameter int NHARTS = 4,
  localparam int HART_W = (NHARTS > 1) ? $clog2(NHARTS) : 1
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  input  wire logic              lookup_i,
  input  wire logic [HART_W-1:0] lookup_hart_i,

  ras_stack_if.consumer          stk_i [NHARTS],

  output logic                   pred_valid_o,
  output logic [XLEN-1:0]        pred_addr_o,
  output logic                   pred_empty_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Flatten the stack ports
  ////////////////////////////////////////////////////////////////////////////

  // Interface arrays need constant indices, copy into plain arrays
  logic [XLEN-1:0]   top_q [NHARTS];
  logic [NHARTS-1:0] top_empty;

  for (genvar h = 0; h < NHARTS; h++) begin : g_tap
    assign top_q[h]     = stk_i[h].q;
    assign top_empty[h] = stk_i[h].empty;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Valid pulses once per lookup
  // Empty reads high until the first answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pred_valid_o <= 1'b0;
      pred_empty_o <= 1'b1;
    end else begin
      pred_valid_o <= lookup_i;
      if (lookup_i) begin
        pred_empty_o <= top_empty[lookup_hart_i];
      end
    end
  end

  // Address sampled from the stack state before this edge
  always_ff @(posedge clk_i) begin
    if (lookup_i) begin
      pred_addr_o <= top_q[lookup_hart_i];
    end
  end

endmodule

`default_nettype wire

//--- design/ras_top.sv
// Return address prediction top level
// Hint decoder feeds one return stack per hart, selector answers lookups

`default_nettype none

module ras_top #(
  parameter int XLEN   = ras_pkg::XLEN_DEF,
  parameter int DEPTH  = ras_pkg::DEPTH_DEF,
  parameter int NHARTS = ras_pkg::NHARTS_DEF,
  localparam int HART_W = (NHARTS > 1) ? $clog2(NHARTS) : 1
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,

  // Decode strobe of one jump instruction
  input  wire logic              instr_valid_i,
  input  wire logic              stall_i,
  input  wire logic [6:0]        opcode_i,
  input  wire logic [4:0]        rd_i,
  input  wire logic [4:0]        rs1_i,
  input  wire logic [XLEN-1:0]   pc_i,
  input  wire logic              rvc_i,
  input  wire logic [HART_W-1:0] hart_i,

  // Prediction lookup
  input  wire logic              lookup_i,
  input  wire logic [HART_W-1:0] lookup_hart_i,
  output logic                   pred_valid_o,
  output logic [XLEN-1:0]        pred_addr_o,
  output logic                   pred_empty_o
);

  // One bundle per hart between decoder, stack and selector
  ras_stack_if #(.XLEN(XLEN)) stk_bus [NHARTS] ();

  ////////////////////////////////////////////////////////////////////////////
  // Hint decode
  ////////////////////////////////////////////////////////////////////////////

  ras_hint_decoder #(
    .XLEN   (XLEN),
    .NHARTS (NHARTS)
  ) u_decoder (
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .opcode_i      (opcode_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .pc_i          (pc_i),
    .rvc_i         (rvc_i),
    .hart_i        (hart_i),
    .stk_o         (stk_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Return stacks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar h = 0; h < NHARTS; h++) begin : g_stack
    ras_stack #(
      .XLEN  (XLEN),
      .DEPTH (DEPTH)
    ) u_stack (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .stk    (stk_bus[h])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////////////////////////////////////////

  ras_pred_select #(
    .XLEN   (XLEN),
    .NHARTS (NHARTS)
  ) u_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup_i),
    .lookup_hart_i (lookup_hart_i),
    .stk_i         (stk_bus),
    .pred_valid_o  (pred_valid_o),
    .pred_addr_o   (pred_addr_o),
    .pred_empty_o  (pred_empty_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// Testbench clock and reset source
// Free running clock, active low reset held for a fixed number of cycles

`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/ras_tb.sv
// Return address prediction testbench
// Directed and LFSR driven jump/lookup traffic, checked against a per hart
// stack model built from the link register hint rules

`default_nettype none

module ras_tb;

  localparam int          XLEN          = 32;
  localparam int          DEPTH         = 4;
  localparam int          NHARTS        = 4;
  localparam int          WAIT_LIMIT    = 20;
  localparam int          RANDOM_CYCLES = 3000;
  localparam logic [31:0] LFSR_SEED     = 32'h5be91e98;
  localparam logic [31:0] LFSR_TAPS     = 32'h80200003;
  localparam logic [6:0]  OPC_JAL       = 7'b110_1111;
  localparam logic [6:0]  OPC_JALR      = 7'b110_0111;
  // Plain ALU opcode, never a jump
  localparam logic [6:0]  OPC_OTHER     = 7'b001_0011;

  logic            clk_i;
  logic            rst_ni;
  logic            instr_valid_i;
  logic            stall_i;
  logic [6:0]      opcode_i;
  logic [4:0]      rd_i;
  logic [4:0]      rs1_i;
  logic [XLEN-1:0] pc_i;
  logic            rvc_i;
  logic [1:0]      hart_i;
  logic            lookup_i;
  logic [1:0]      lookup_hart_i;
  logic            pred_valid_o;
  logic [XLEN-1:0] pred_addr_o;
  logic            pred_empty_o;

  // Model state, index 0 of each queue is the top of stack
  logic [XLEN-1:0] mq [NHARTS][$];
  logic [XLEN-1:0] mlast [NHARTS];
  logic            mpushed [NHARTS];

  logic [31:0]     lfsr_state;
  string           cur_test;
  int              checks;
  int              errors;
  int              test_errors;
  int              tests_run;
  int              tests_failed;

  tb_clock #(.PERIOD(4), .RESET_CYCLES(5)) u_clock (.clk_o(clk_i), .rst_no(rst_ni));

  ras_top #(
    .XLEN   (XLEN),
    .DEPTH  (DEPTH),
    .NHARTS (NHARTS)
  ) DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .stall_i       (stall_i),
    .opcode_i      (opcode_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .pc_i          (pc_i),
    .rvc_i         (rvc_i),
    .hart_i        (hart_i),
    .lookup_i      (lookup_i),
    .lookup_hart_i (lookup_hart_i),
    .pred_valid_o  (pred_valid_o),
    .pred_addr_o   (pred_addr_o),
    .pred_empty_o  (pred_empty_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
      else lfsr_state = lfsr_state >> 1;
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Mostly x1 and x5, sometimes x0, x2 or any register
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    r = rand_bits(3);
    case (r[2:0])
      3'd0, 3'd1, 3'd2: return 5'd1;
      3'd3, 3'd4:       return 5'd5;
      3'd5:             return 5'd0;
      3'd6:             return 5'd2;
      default: begin
        r = rand_bits(5);
        return r[4:0];
      end
    endcase
  endfunction

  // Link register hint table, written out rule by rule
  function automatic ras_pkg::ras_action_e hint_action(input logic [6:0] opc,
                                                       input logic [4:0] rd,
                                                       input logic [4:0] rs1);
    logic rd_l;
    logic rs_l;
    rd_l = (rd == 5'd1) || (rd == 5'd5);
    rs_l = (rs1 == 5'd1) || (rs1 == 5'd5);
    if (opc == OPC_JAL) return rd_l ? ras_pkg::RAS_PUSH : ras_pkg::RAS_NONE;
    if (opc != OPC_JALR) return ras_pkg::RAS_NONE;
    if (rd_l && !rs_l) return ras_pkg::RAS_PUSH;
    if (!rd_l && rs_l) return ras_pkg::RAS_POP;
    if (rd_l && rs_l) return (rd == rs1) ? ras_pkg::RAS_PUSH : ras_pkg::RAS_POP_PUSH;
    return ras_pkg::RAS_NONE;
  endfunction

  task automatic model_apply(input ras_pkg::ras_action_e act, input logic [1:0] h,
                             input logic [XLEN-1:0] addr);
    case (act)
      ras_pkg::RAS_PUSH: begin
        // Full stack loses its oldest entry
        if (mq[h].size() == DEPTH) void'(mq[h].pop_back());
        mq[h].push_front(addr);
        mlast[h]   = addr;
        mpushed[h] = 1'b1;
      end
      ras_pkg::RAS_POP: begin
        if (mq[h].size() != 0) void'(mq[h].pop_front());
      end
      ras_pkg::RAS_POP_PUSH: begin
        // Depth unchanged, top replaced
        if (mq[h].size() != 0) mq[h][0] = addr;
        mlast[h]   = addr;
        mpushed[h] = 1'b1;
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////

  task automatic next_edge();
    @(posedge clk_i);
    #1;
  endtask

  task automatic drive_idle();
    instr_valid_i = 1'b0;
    stall_i       = 1'b0;
    opcode_i      = '0;
    rd_i          = '0;
    rs1_i         = '0;
    pc_i          = '0;
    rvc_i         = 1'b0;
    hart_i        = '0;
    lookup_i      = 1'b0;
    lookup_hart_i = '0;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("ERROR in %s: %s", cur_test, msg);
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR in %s: %s", cur_test, msg);
    $display("Something failed");
    $finish;
  endtask

  // One jump slot and one lookup slot in the same cycle
  task automatic run_cycle(input logic v, input logic st, input logic [6:0] opc,
                           input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [XLEN-1:0] pc, input logic rvc, input logic [1:0] hart,
                           input logic lk, input logic [1:0] lh);
    logic [XLEN-1:0] exp_addr;
    logic            exp_empty;
    logic            exp_known;
    int              waited;
    instr_valid_i = v;
    stall_i       = st;
    opcode_i      = opc;
    rd_i          = rd;
    rs1_i         = rs1;
    pc_i          = pc;
    rvc_i         = rvc;
    hart_i        = hart;
    lookup_i      = lk;
    lookup_hart_i = lh;
    // Lookup answers with the stack as it stands before this edge
    exp_empty = (mq[lh].size() == 0);
    exp_known = mpushed[lh];
    if (exp_empty) exp_addr = mlast[lh];
    else exp_addr = mq[lh][0];
    if (v && !st) model_apply(hint_action(opc, rd, rs1), hart, pc + (rvc ? 32'd2 : 32'd4));
    next_edge();
    drive_idle();
    if (lk) begin
      waited = 1;
      while (!pred_valid_o && waited < WAIT_LIMIT) begin
        next_edge();
        waited++;
      end
      if (!pred_valid_o) begin
        abort_run("lookup got no answer before the timeout");
      end else begin
        if (waited != 1) report_error("lookup answered later than one cycle");
        check_value("pred_empty_o", {31'd0, exp_empty}, {31'd0, pred_empty_o});
        if (exp_known) check_value("pred_addr_o", exp_addr, pred_addr_o);
      end
    end else if (pred_valid_o) begin
      report_error("pred_valid_o high in a cycle without a lookup");
    end
  endtask

  task automatic jump(input logic [6:0] opc, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [XLEN-1:0] pc, input logic rvc, input logic [1:0] hart);
    run_cycle(1'b1, 1'b0, opc, rd, rs1, pc, rvc, hart, 1'b0, 2'd0);
  endtask

  task automatic lookup(input logic [1:0] h);
    run_cycle(1'b0, 1'b0, 7'd0, 5'd0, 5'd0, '0, 1'b0, 2'd0, 1'b1, h);
  endtask

  // JALR x0,x1 return with a lookup of the same hart in that cycle
  task automatic return_lookup(input logic [XLEN-1:0] pc, input logic [1:0] h);
    run_cycle(1'b1, 1'b0, OPC_JALR, 5'd0, 5'd1, pc, 1'b0, h, 1'b1, h);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %s finished with %0d errors", cur_test, test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int              waited;
    logic [31:0]     r;
    logic [6:0]      opc;
    logic            rnd_valid;
    logic            rnd_stall;
    logic [4:0]      rnd_rd;
    logic [4:0]      rnd_rs1;
    logic [XLEN-1:0] rnd_pc;
    logic            rnd_rvc;
    logic [1:0]      rnd_hart;
    logic            rnd_lookup;
    logic [1:0]      rnd_lookup_hart;
    drive_idle();
    lfsr_state = LFSR_SEED;
    checks     = 0;
    errors     = 0;
    tests_run  = 0;
    tests_failed = 0;
    cur_test   = "reset";
    for (int h = 0; h < NHARTS; h++) begin
      mlast[h]   = '0;
      mpushed[h] = 1'b0;
    end
    waited = 0;
    while (!rst_ni && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (!rst_ni) begin
      abort_run("reset was never released");
    end else begin
      next_edge();

      // Every hart empty, valid for one cycle only
      start_test("reset_empty");
      for (int h = 0; h < NHARTS; h++) begin
        lookup(2'(h));
        run_cycle(1'b0, 1'b0, 7'd0, 5'd0, 5'd0, '0, 1'b0, 2'd0, 1'b0, 2'd0);
      end
      end_test();

      // Calls then returns in LIFO order, PC+4 and PC+2
      start_test("call_return");
      jump(OPC_JAL, 5'd1, 5'd0, 32'h0000_1000, 1'b0, 2'd0);
      jump(OPC_JAL, 5'd1, 5'd0, 32'h0000_2000, 1'b1, 2'd0);
      jump(OPC_JAL, 5'd5, 5'd0, 32'h0000_3006, 1'b0, 2'd0);
      for (int i = 0; i < 3; i++) return_lookup(32'h0000_8000, 2'd0);
      lookup(2'd0);
      end_test();

      // Six pushes into four entries, then drain past empty
      start_test("overflow");
      for (int i = 0; i < 6; i++) begin
        jump(OPC_JAL, 5'd1, 5'd0, 32'h0001_0000 + 32'(i * 16), 1'b0, 2'd1);
      end
      for (int i = 0; i < 5; i++) return_lookup(32'h0001_8000, 2'd1);
      lookup(2'd1);
      jump(OPC_JAL, 5'd1, 5'd0, 32'h0001_9000, 1'b1, 2'd1);
      lookup(2'd1);
      end_test();

      // Coroutine swap, rd equal rs1, and no link register
      start_test("hint_cases");
      jump(OPC_JAL, 5'd1, 5'd0, 32'h0000_4000, 1'b0, 2'd2);
      jump(OPC_JAL, 5'd1, 5'd0, 32'h0000_4100, 1'b1, 2'd2);
      jump(OPC_JALR, 5'd1, 5'd5, 32'h0000_4200, 1'b0, 2'd2);
      lookup(2'd2);
      jump(OPC_JALR, 5'd5, 5'd5, 32'h0000_4300, 1'b1, 2'd2);
      lookup(2'd2);
      jump(OPC_JALR, 5'd0, 5'd2, 32'h0000_4400, 1'b0, 2'd2);
      jump(OPC_JAL, 5'd0, 5'd0, 32'h0000_4500, 1'b0, 2'd2);
      for (int i = 0; i < 4; i++) return_lookup(32'h0000_4600, 2'd2);
      end_test();

      // Stalled or invalid slots change nothing, harts stay apart
      start_test("stall_isolation");
      jump(OPC_JAL, 5'd1, 5'd0, 32'h0000_5000, 1'b0, 2'd3);
      jump(OPC_JAL, 5'd5, 5'd0, 32'h0000_5100, 1'b0, 2'd3);
      for (int i = 0; i < 4; i++) begin
        run_cycle(1'b1, 1'b1, OPC_JAL, 5'd1, 5'd0, 32'h0000_6000, 1'b0, 2'(i), 1'b1, 2'd3);
        run_cycle(1'b1, 1'b1, OPC_JALR, 5'd0, 5'd1, 32'h0000_6100, 1'b0, 2'd3, 1'b1, 2'(i));
        run_cycle(1'b0, 1'b0, OPC_JAL, 5'd1, 5'd0, 32'h0000_6200, 1'b0, 2'd3, 1'b1, 2'd3);
      end
      for (int i = 0; i < 3; i++) begin
        run_cycle(1'b1, 1'b0, OPC_JAL, 5'd1, 5'd0, 32'h0000_7000, 1'b1, 2'd0, 1'b1, 2'd3);
      end
      run_cycle(1'b1, 1'b0, OPC_JALR, 5'd0, 5'd5, 32'h0000_7100, 1'b0, 2'd0, 1'b1, 2'd3);
      lookup(2'd0);
      end_test();

      // Mixed traffic, every lookup checked against the model
      start_test("random_mix");
      for (int n = 0; n < RANDOM_CYCLES; n++) begin
        r = rand_bits(2);
        if (r[1:0] == 2'd2) opc = OPC_JAL;
        else if (r[1:0] == 2'd3) opc = OPC_OTHER;
        else opc = OPC_JALR;
        rnd_valid = (rand_bits(3) != 32'd0);
        rnd_stall = (rand_bits(3) == 32'd0);
        rnd_rd    = pick_reg();
        rnd_rs1   = pick_reg();
        // Even PC, bit 0 is never set
        r         = rand_bits(31);
        rnd_pc    = {r[30:0], 1'b0};
        r         = rand_bits(1);
        rnd_rvc   = r[0];
        r         = rand_bits(2);
        rnd_hart  = r[1:0];
        r          = rand_bits(1);
        rnd_lookup = r[0];
        r               = rand_bits(2);
        rnd_lookup_hart = r[1:0];
        run_cycle(rnd_valid, rnd_stall, opc, rnd_rd, rnd_rs1, rnd_pc, rnd_rvc, rnd_hart,
                  rnd_lookup, rnd_lookup_hart);
      end
      end_test();

      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- ras_top.f
design/ras_pkg.sv
design/ras_stack_if.sv
design/ras_hint_decoder.sv
design/ras_stack.sv
design/ras_pred_select.sv
design/ras_top.sv
tests/tb_clock.sv
tests/ras_tb.sv

//--- run.sh
#!/bin/sh
# Build the return address prediction testbench with Verilator and run it
# The run passes only when the log holds the pass line

rm -rf obj_dir sim.log
verilator --binary --timing -f ras_top.f --top-module ras_tb -o ras_sim \
  && ./obj_dir/ras_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Everything OK$" sim.log 2>/dev/null \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation did not pass"; exit 1; }
